// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rv_core_pkg.sv
      - logic/rv_fetch.sv
      - logic/rv_decode.sv
      - logic/rv_regfile.sv
      - logic/rv_csr_file.sv
      - logic/rv_execute.sv
      - logic/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/rv_core_mem_model.sv
      - verification/rv_core_tb.sv

// ==== filelist.f ====
+incdir+include
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_csr_file.sv
logic/rv_execute.sv
logic/rv_core.sv
verification/rv_core_mem_model.sv
verification/rv_core_tb.sv

// ==== include/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define XLEN          64
`define RESET_PC      64'h8000_0000
`define ALU_SEL_W     3

`define OP_LUI        7'b0110111
`define OP_AUIPC      7'b0010111
`define OP_JAL        7'b1101111
`define OP_JALR       7'b1100111
`define OP_BRANCH     7'b1100011
`define OP_LOAD       7'b0000011
`define OP_STORE      7'b0100011
`define OP_IMM        7'b0010011
`define OP_REG        7'b0110011
`define OP_SYSTEM     7'b1110011

`define F3_ADD        3'b000
`define F3_XOR        3'b100
`define F3_OR         3'b110
`define F3_AND        3'b111
`define F3_BEQ        3'b000
`define F3_BNE        3'b001
`define F3_LBU        3'b100
`define F3_LW         3'b010
`define F3_LD         3'b011
`define F3_SB         3'b000
`define F3_SW         3'b010
`define F3_SD         3'b011
`define F3_CSRRW      3'b001
`define F3_PRIV       3'b000
`define F7_ADD        7'b0000000
`define F7_SUB        7'b0100000
`define F12_ECALL     12'h000
`define F12_MRET      12'h302

`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

`define CAUSE_ECALL_M 11

`endif

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  output xlen_t      inst_addr_o,
  input  inst_t      inst_i,
  output logic       ram_re_o,
  output xlen_t      ram_raddr_o,
  input  xlen_t      ram_rdata_i,
  output logic       ram_we_o,
  output xlen_t      ram_waddr_o,
  output xlen_t      ram_wdata_o,
  output byte_mask_t wmask_o
);

  xlen_t      pc;
  reg_addr_t  raddr1;        // rs1 index
  reg_addr_t  raddr2;        // rs2 index
  xlen_t      rdata1;
  xlen_t      rdata2;
  xlen_t      op1;
  xlen_t      op2;
  xlen_t      store_data;
  alu_sel_t   alu_sel;
  mem_kind_t  mem_kind;
  logic       load;
  logic       store;
  logic       dec_reg_we;
  reg_addr_t  dec_reg_waddr;
  logic       jump_valid;
  xlen_t      jump_target;
  logic       link;
  logic [1:0] csr_op;
  csr_addr_t  csr_addr;
  xlen_t      csr_rdata;
  logic       redirect_valid; // trap entry or mret
  xlen_t      redirect_pc;
  logic       reg_we;
  reg_addr_t  reg_waddr;
  xlen_t      reg_wdata;
  wire        csr_wb = (csr_op == CSR_OP_RW);

  assign inst_addr_o = pc;

  rv_fetch u_fetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .jump_valid_i     (jump_valid),
    .jump_target_i    (jump_target),
    .pc_o             (pc)
  );

  rv_decode u_decode (
    .pc_i          (pc),
    .inst_i        (inst_i),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .reg_waddr_o   (dec_reg_waddr),
    .reg_we_o      (dec_reg_we),
    .op1_o         (op1),
    .op2_o         (op2),
    .store_data_o  (store_data),
    .alu_sel_o     (alu_sel),
    .mem_kind_o    (mem_kind),
    .load_o        (load),
    .store_o       (store),
    .jump_valid_o  (jump_valid),
    .jump_target_o (jump_target),
    .link_o        (link),
    .csr_op_o      (csr_op),
    .csr_addr_o    (csr_addr)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .waddr_i  (reg_waddr),
    .wen_i    (reg_we),
    .wdata_i  (reg_wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  rv_csr_file u_csr_file (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_i             (pc),
    .rs1_data_i       (rdata1),
    .csr_op_i         (csr_op),
    .csr_addr_i       (csr_addr),
    .csr_rdata_o      (csr_rdata),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc)
  );

  rv_execute u_execute (
    .rst_n        (rst_n),
    .op1_i        (op1),
    .op2_i        (op2),
    .store_data_i (store_data),
    .pc_i         (pc),
    .csr_rdata_i  (csr_rdata),
    .alu_sel_i    (alu_sel),
    .mem_kind_i   (mem_kind),
    .load_i       (load),
    .store_i      (store),
    .reg_we_i     (dec_reg_we),
    .link_i       (link),
    .csr_wb_i     (csr_wb),
    .reg_waddr_i  (dec_reg_waddr),
    .ram_rdata_i  (ram_rdata_i),
    .ram_re_o     (ram_re_o),
    .ram_we_o     (ram_we_o),
    .ram_raddr_o  (ram_raddr_o),
    .ram_waddr_o  (ram_waddr_o),
    .ram_wdata_o  (ram_wdata_o),
    .wmask_o      (wmask_o),
    .reg_we_o     (reg_we),
    .reg_waddr_o  (reg_waddr),
    .reg_wdata_o  (reg_wdata)
  );

endmodule

// ==== logic/rv_core_pkg.sv ====
`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0]      xlen_t;
  typedef logic [31:0]           inst_t;
  typedef logic [4:0]            reg_addr_t;
  typedef logic [11:0]           csr_addr_t;
  typedef logic [`ALU_SEL_W-1:0] alu_sel_t;
  typedef logic [2:0]            mem_kind_t;
  typedef logic [7:0]            byte_mask_t;

  // alu operation select
  localparam alu_sel_t ALU_ADD  = 3'd0;
  localparam alu_sel_t ALU_SUB  = 3'd1;
  localparam alu_sel_t ALU_AND  = 3'd2;
  localparam alu_sel_t ALU_OR   = 3'd3;
  localparam alu_sel_t ALU_XOR  = 3'd4;
  localparam alu_sel_t ALU_PASS = 3'd5; // result is op2

  // memory access width and signedness
  localparam mem_kind_t MEM_NONE = 3'd0;
  localparam mem_kind_t MEM_BU   = 3'd1; // byte, zero extended
  localparam mem_kind_t MEM_WS   = 3'd2; // word, sign extended
  localparam mem_kind_t MEM_D    = 3'd3; // double word

  // csr block operation
  localparam logic [1:0] CSR_OP_NONE  = 2'd0;
  localparam logic [1:0] CSR_OP_RW    = 2'd1;
  localparam logic [1:0] CSR_OP_ECALL = 2'd2;
  localparam logic [1:0] CSR_OP_MRET  = 2'd3;

endpackage

// ==== logic/rv_csr_file.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_csr_file import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  xlen_t      pc_i,
  input  xlen_t      rs1_data_i,
  input  logic [1:0] csr_op_i,
  input  csr_addr_t  csr_addr_i,
  output xlen_t      csr_rdata_o,
  output logic       redirect_valid_o,
  output xlen_t      redirect_pc_o
);

  localparam int    MIE_BIT       = 3;
  localparam int    MPIE_BIT      = 7;
  localparam xlen_t MSTATUS_RESET = xlen_t'(64'h1800); // mpp = machine

  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mstatus_q;
  logic  ecall;
  logic  mret;

  assign ecall = (csr_op_i == CSR_OP_ECALL);
  assign mret  = (csr_op_i == CSR_OP_MRET);

  always_comb begin
    case (csr_addr_i)
      `CSR_MTVEC:   csr_rdata_o = mtvec_q;
      `CSR_MEPC:    csr_rdata_o = mepc_q;
      `CSR_MCAUSE:  csr_rdata_o = mcause_q;
      `CSR_MSTATUS: csr_rdata_o = mstatus_q;
      default:      csr_rdata_o = '0; // unimplemented csr
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mstatus_q <= MSTATUS_RESET;
    end else if (ecall) begin
      mepc_q                <= pc_i;
      mcause_q              <= xlen_t'(`CAUSE_ECALL_M);
      mstatus_q[MPIE_BIT]   <= mstatus_q[MIE_BIT];
      mstatus_q[MIE_BIT]    <= 1'b0;
      mstatus_q[12:11]      <= 2'b11;
    end else if (mret) begin
      mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
      mstatus_q[MPIE_BIT] <= 1'b1;
    end else if (csr_op_i == CSR_OP_RW) begin
      case (csr_addr_i)
        `CSR_MTVEC:   mtvec_q   <= {rs1_data_i[`XLEN-1:2], 2'b00}; // direct mode only
        `CSR_MEPC:    mepc_q    <= {rs1_data_i[`XLEN-1:2], 2'b00};
        `CSR_MCAUSE:  mcause_q  <= rs1_data_i;
        `CSR_MSTATUS: mstatus_q <= rs1_data_i;
        default: ;
      endcase
    end
  end

  assign redirect_valid_o = ecall || mret;
  assign redirect_pc_o    = ecall ? mtvec_q : mepc_q;

  // trap vector and return address keep the fetch word aligned
  a_redirect_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) redirect_valid_o |-> redirect_pc_o[1:0] == 2'b00
  );

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_decode import rv_core_pkg::*; (
  input  xlen_t     pc_i,
  input  inst_t     inst_i,
  input  xlen_t     rdata1_i,
  input  xlen_t     rdata2_i,
  output reg_addr_t raddr1_o,
  output reg_addr_t raddr2_o,
  output reg_addr_t reg_waddr_o,
  output logic      reg_we_o,
  output xlen_t     op1_o,
  output xlen_t     op2_o,
  output xlen_t     store_data_o,
  output alu_sel_t  alu_sel_o,
  output mem_kind_t mem_kind_o,
  output logic      load_o,
  output logic      store_o,
  output logic      jump_valid_o,
  output xlen_t     jump_target_o,
  output logic      link_o,        // write pc+4 to rd
  output logic [1:0] csr_op_o,
  output csr_addr_t csr_addr_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       rs_equal;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  assign raddr1_o    = inst_i[19:15];
  assign raddr2_o    = inst_i[24:20];
  assign reg_waddr_o = inst_i[11:7];
  assign csr_addr_o  = inst_i[31:20];
  assign rs_equal    = (rdata1_i == rdata2_i); // beq/bne compare

  always_comb begin
    reg_we_o      = 1'b0;        // unknown encodings fall through as no-op
    op1_o         = rdata1_i;
    op2_o         = rdata2_i;
    store_data_o  = rdata2_i;
    alu_sel_o     = ALU_ADD;
    mem_kind_o    = MEM_NONE;
    load_o        = 1'b0;
    store_o       = 1'b0;
    jump_valid_o  = 1'b0;
    jump_target_o = pc_i + imm_b;
    link_o        = 1'b0;
    csr_op_o      = CSR_OP_NONE;
    case (opcode)
      `OP_LUI: begin
        reg_we_o  = 1'b1;
        op2_o     = imm_u;
        alu_sel_o = ALU_PASS;
      end
      `OP_AUIPC: begin
        reg_we_o = 1'b1;
        op1_o    = pc_i;
        op2_o    = imm_u;
      end
      `OP_JAL: begin
        reg_we_o      = 1'b1;
        link_o        = 1'b1;
        jump_valid_o  = 1'b1;
        jump_target_o = pc_i + imm_j;
      end
      `OP_JALR: begin
        reg_we_o      = 1'b1;
        link_o        = 1'b1;
        jump_valid_o  = 1'b1;
        jump_target_o = (rdata1_i + imm_i) & ~xlen_t'(1); // clear bit 0
      end
      `OP_BRANCH: begin
        if (funct3 == `F3_BEQ) begin
          jump_valid_o = rs_equal;
        end else if (funct3 == `F3_BNE) begin
          jump_valid_o = !rs_equal;
        end
      end
      `OP_LOAD: begin
        op2_o = imm_i;
        case (funct3)
          `F3_LBU: mem_kind_o = MEM_BU;
          `F3_LW:  mem_kind_o = MEM_WS;
          `F3_LD:  mem_kind_o = MEM_D;
          default: mem_kind_o = MEM_NONE;
        endcase
        load_o   = (mem_kind_o != MEM_NONE);
        reg_we_o = load_o;
      end
      `OP_STORE: begin
        op2_o = imm_s;
        case (funct3)
          `F3_SB:  mem_kind_o = MEM_BU;
          `F3_SW:  mem_kind_o = MEM_WS;
          `F3_SD:  mem_kind_o = MEM_D;
          default: mem_kind_o = MEM_NONE;
        endcase
        store_o = (mem_kind_o != MEM_NONE);
      end
      `OP_IMM: begin
        op2_o    = imm_i;
        reg_we_o = (funct3 == `F3_ADD); // addi only
      end
      `OP_REG: begin
        if (funct7 == `F7_ADD || funct7 == `F7_SUB) begin
          reg_we_o = 1'b1;
          case (funct3)
            `F3_ADD: alu_sel_o = (funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
            `F3_XOR: alu_sel_o = ALU_XOR;
            `F3_OR:  alu_sel_o = ALU_OR;
            `F3_AND: alu_sel_o = ALU_AND;
            default: reg_we_o  = 1'b0;
          endcase
        end
      end
      `OP_SYSTEM: begin
        if (funct3 == `F3_CSRRW) begin
          reg_we_o = 1'b1;  // old csr value goes to rd
          csr_op_o = CSR_OP_RW;
        end else if (funct3 == `F3_PRIV && inst_i[31:20] == `F12_ECALL) begin
          csr_op_o = CSR_OP_ECALL;
        end else if (funct3 == `F3_PRIV && inst_i[31:20] == `F12_MRET) begin
          csr_op_o = CSR_OP_MRET;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
  input  logic       rst_n,
  input  xlen_t      op1_i,
  input  xlen_t      op2_i,
  input  xlen_t      store_data_i,
  input  xlen_t      pc_i,
  input  xlen_t      csr_rdata_i,
  input  alu_sel_t   alu_sel_i,
  input  mem_kind_t  mem_kind_i,
  input  logic       load_i,
  input  logic       store_i,
  input  logic       reg_we_i,
  input  logic       link_i,
  input  logic       csr_wb_i,
  input  reg_addr_t  reg_waddr_i,
  input  xlen_t      ram_rdata_i,   // aligned double word
  output logic       ram_re_o,
  output logic       ram_we_o,
  output xlen_t      ram_raddr_o,
  output xlen_t      ram_waddr_o,
  output xlen_t      ram_wdata_o,
  output byte_mask_t wmask_o,
  output logic       reg_we_o,
  output reg_addr_t  reg_waddr_o,
  output xlen_t      reg_wdata_o
);

  xlen_t      alu_res;
  xlen_t      dword_addr;
  logic [5:0] lane_shift;
  byte_mask_t lane_mask;
  xlen_t      load_shifted;
  xlen_t      load_data;

  always_comb begin
    case (alu_sel_i)
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_PASS: alu_res = op2_i;
      default:  alu_res = op1_i + op2_i; // add, also the address adder
    endcase
  end

  assign dword_addr = {alu_res[$bits(xlen_t)-1:3], 3'b000};
  assign lane_shift = {alu_res[2:0], 3'b000}; // byte offset in bits

  always_comb begin
    case (mem_kind_i)
      MEM_BU:  lane_mask = byte_mask_t'(8'h01) << alu_res[2:0];
      MEM_WS:  lane_mask = byte_mask_t'(8'h0f) << alu_res[2:0];
      MEM_D:   lane_mask = 8'hff;
      default: lane_mask = 8'h00;
    endcase
  end

  assign ram_re_o    = rst_n && load_i;
  assign ram_we_o    = rst_n && store_i;
  assign ram_raddr_o = dword_addr;
  assign ram_waddr_o = dword_addr;
  assign ram_wdata_o = store_data_i << lane_shift;
  assign wmask_o     = ram_we_o ? lane_mask : '0;

  assign load_shifted = ram_rdata_i >> lane_shift;

  always_comb begin
    case (mem_kind_i)
      MEM_BU:  load_data = {{($bits(xlen_t)-8){1'b0}}, load_shifted[7:0]};
      MEM_WS:  load_data = {{($bits(xlen_t)-32){load_shifted[31]}}, load_shifted[31:0]};
      MEM_D:   load_data = ram_rdata_i;
      default: load_data = '0;
    endcase
  end

  always_comb begin
    if (csr_wb_i) begin
      reg_wdata_o = csr_rdata_i;     // csrrw returns the old value
    end else if (link_i) begin
      reg_wdata_o = pc_i + xlen_t'(4);
    end else if (load_i) begin
      reg_wdata_o = load_data;
    end else begin
      reg_wdata_o = alu_res;
    end
  end

  assign reg_we_o    = rst_n && reg_we_i;
  assign reg_waddr_o = reg_waddr_i;

endmodule

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_fetch import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  redirect_valid_i, // trap entry or return
  input  xlen_t redirect_pc_i,
  input  logic  jump_valid_i,     // jal, jalr or taken branch
  input  xlen_t jump_target_i,
  output xlen_t pc_o
);

  xlen_t pc_q;
  xlen_t pc_next;

  always_comb begin
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;  // csr redirect wins
    end else if (jump_valid_i) begin
      pc_next = jump_target_i;
    end else begin
      pc_next = pc_q + xlen_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // targets come from decode and the csr block, both must keep alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_o[1:0] == 2'b00);

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  input  reg_addr_t waddr_i,
  input  logic      wen_i,
  input  xlen_t     wdata_i,
  output xlen_t     rdata1_o,
  output xlen_t     rdata2_o
);

  xlen_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  // no x may leak from the register array once out of reset
  a_rdata_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({rdata1_o, rdata2_o})
  );

endmodule

// ==== verification/rv_core_mem_model.sv ====
`timescale 1ns/1ps

module rv_core_mem_model import rv_core_pkg::*; (
  input  logic       clk,
  input  xlen_t      inst_addr_i,
  output inst_t      inst_o,
  input  logic       re_i,
  input  xlen_t      raddr_i,
  output xlen_t      rdata_o,
  input  logic       we_i,
  input  xlen_t      waddr_i,
  input  xlen_t      wdata_i,
  input  byte_mask_t wmask_i
);

  localparam int DEPTH     = 1024; // 8 KiB window, address bits 12:3
  localparam int LOG_DEPTH = 64;

  xlen_t      mem [DEPTH];
  xlen_t      log_addr [LOG_DEPTH];
  xlen_t      log_data [LOG_DEPTH];
  byte_mask_t log_mask [LOG_DEPTH];
  int         log_count;
  logic [9:0] fetch_idx;
  logic [9:0] read_idx;
  logic [9:0] write_idx;

  assign fetch_idx = inst_addr_i[12:3];
  assign read_idx  = raddr_i[12:3];
  assign write_idx = waddr_i[12:3];

  assign inst_o  = inst_addr_i[2] ? mem[fetch_idx][63:32] : mem[fetch_idx][31:0];
  assign rdata_o = re_i ? mem[read_idx] : '0;

  // masked byte write plus one log entry per store
  always @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask_i[b]) begin
          mem[write_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      if (log_count < LOG_DEPTH) begin
        log_addr[log_count] <= waddr_i;
        log_data[log_count] <= wdata_i;
        log_mask[log_count] <= wmask_i;
        log_count           <= log_count + 1;
      end
    end
  end

  task automatic clear();
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0; // zero decodes as a no-op
    end
    log_count = 0;
  endtask

  task automatic write_word(input xlen_t addr, input inst_t word);
    if (addr[2]) begin
      mem[addr[12:3]][63:32] = word;
    end else begin
      mem[addr[12:3]][31:0] = word;
    end
  endtask

  task automatic write_dword(input xlen_t addr, input xlen_t data);
    mem[addr[12:3]] = data;
  endtask

  function automatic xlen_t read_dword(input xlen_t addr);
    return mem[addr[12:3]];
  endfunction

  initial clear();

endmodule

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_tb import rv_core_pkg::*;;

  localparam xlen_t DATA_BASE = `RESET_PC + 64'h1000; // auipc x10, 1 at the reset pc

  logic       clk;
  logic       rst_n;
  xlen_t      inst_addr;
  inst_t      inst;
  logic       ram_re;
  xlen_t      ram_raddr;
  xlen_t      ram_rdata;
  logic       ram_we;
  xlen_t      ram_waddr;
  xlen_t      ram_wdata;
  byte_mask_t wmask;
  xlen_t      emit_addr;     // next program slot
  xlen_t      pc_trace [$];  // one entry per retired instruction
  xlen_t      expected_pcs [$];

  rv_core UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_addr_o (inst_addr),
    .inst_i      (inst),
    .ram_re_o    (ram_re),
    .ram_raddr_o (ram_raddr),
    .ram_rdata_i (ram_rdata),
    .ram_we_o    (ram_we),
    .ram_waddr_o (ram_waddr),
    .ram_wdata_o (ram_wdata),
    .wmask_o     (wmask)
  );

  rv_core_mem_model mem_model (
    .clk         (clk),
    .inst_addr_i (inst_addr),
    .inst_o      (inst),
    .re_i        (ram_re),
    .raddr_i     (ram_raddr),
    .rdata_o     (ram_rdata),
    .we_i        (ram_we),
    .waddr_i     (ram_waddr),
    .wdata_i     (ram_wdata),
    .wmask_i     (wmask)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      pc_trace.push_back(inst_addr);
    end
  end

  function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  // lui then addi, both immediates sign extended to 64 bits
  function automatic xlen_t lui_addi_value(input logic [19:0] hi, input logic [11:0] lo);
    return {{32{hi[19]}}, hi, 12'h000} + {{52{lo[11]}}, lo};
  endfunction

  task automatic halt_on_error();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_value(input xlen_t got, input xlen_t expected, input string what);
    if (got !== expected) begin
      $display("FAIL time=%0t %s: got %h, expected %h", $time, what, got, expected);
      halt_on_error();
    end
  endtask

  task automatic place(input inst_t word);
    mem_model.write_word(emit_addr, word);
    emit_addr = emit_addr + 4;
  endtask

  task automatic start_program();
    @(negedge clk);
    rst_n = 1'b0;
    mem_model.clear();
    pc_trace.delete();
    expected_pcs.delete();
    emit_addr = `RESET_PC;
  endtask

  task automatic release_reset();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_for_stores(input int count, input int max_cycles);
    int cycles;
    cycles = 0;
    while (mem_model.log_count < count) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        $display("timeout: expected %0d stores, saw %0d", count, mem_model.log_count);
        halt_on_error();
      end
    end
  endtask

  task automatic wait_for_pc(input xlen_t target, input int max_cycles);
    int cycles;
    cycles = 0;
    while (inst_addr !== target) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        $display("timeout: pc never reached %h, last pc %h", target, inst_addr);
        halt_on_error();
      end
    end
  endtask

  task automatic compare_trace();
    compare_value(pc_trace.size(), expected_pcs.size(), "fetch trace length");
    for (int i = 0; i < expected_pcs.size(); i++) begin
      compare_value(pc_trace[i], expected_pcs[i], $sformatf("fetch address %0d", i));
    end
  endtask

  task automatic reset_and_straight_line();
    start_program();
    place(s_type(12'd0, 0, 0, `F3_SD)); // store at reset pc, must stay idle
    place(i_type(12'd1, 0, `F3_ADD, 1, `OP_IMM));
    place(i_type(12'd2, 0, `F3_ADD, 2, `OP_IMM));
    place(i_type(12'd3, 0, `F3_ADD, 3, `OP_IMM));
    place(j_type(21'd0, 0));
    @(negedge clk);
    compare_value(inst_addr, `RESET_PC, "pc in reset");
    compare_value(ram_we, 1'b0, "ram_we in reset");
    mem_model.write_word(`RESET_PC, i_type(12'd0, 0, `F3_LD, 5, `OP_LOAD)); // now a load
    @(negedge clk);
    compare_value(ram_re, 1'b0, "ram_re in reset");
    release_reset();
    compare_value(inst_addr, `RESET_PC, "first fetch after reset");
    for (int i = 0; i < 4; i++) begin
      expected_pcs.push_back(`RESET_PC + 4*i);
    end
    wait_for_pc(`RESET_PC + 16, 50);
    compare_trace();
  endtask

  task automatic alu_and_upper_imm();
    logic [19:0] hi_a;
    logic [19:0] hi_b;
    logic [19:0] upper;
    logic [11:0] lo_a;
    logic [11:0] lo_b;
    xlen_t       a;
    xlen_t       b;
    xlen_t       auipc_pc;
    xlen_t       expected [7];
    {hi_a, lo_a}  = $urandom();
    {hi_b, lo_b}  = $urandom();
    upper = 20'($urandom());
    a = lui_addi_value(hi_a, lo_a);
    b = lui_addi_value(hi_b, lo_b);
    start_program();
    place(u_type(20'h00001, 10, `OP_AUIPC));
    place(u_type(hi_a, 1, `OP_LUI));
    place(i_type(lo_a, 1, `F3_ADD, 1, `OP_IMM));
    place(u_type(hi_b, 2, `OP_LUI));
    place(i_type(lo_b, 2, `F3_ADD, 2, `OP_IMM));
    place(r_type(`F7_ADD, 2, 1, `F3_ADD, 3));
    place(s_type(12'd0, 3, 10, `F3_SD));
    place(r_type(`F7_SUB, 2, 1, `F3_ADD, 4));
    place(s_type(12'd8, 4, 10, `F3_SD));
    place(r_type(`F7_ADD, 2, 1, `F3_AND, 5));
    place(s_type(12'd16, 5, 10, `F3_SD));
    place(r_type(`F7_ADD, 2, 1, `F3_OR, 6));
    place(s_type(12'd24, 6, 10, `F3_SD));
    place(r_type(`F7_ADD, 2, 1, `F3_XOR, 7));
    place(s_type(12'd32, 7, 10, `F3_SD));
    auipc_pc = emit_addr;
    place(u_type(upper, 8, `OP_AUIPC));
    place(s_type(12'd40, 8, 10, `F3_SD));
    place(r_type(`F7_ADD, 2, 1, `F3_ADD, 0)); // x0 destination is discarded
    place(s_type(12'd48, 0, 10, `F3_SD));
    place(j_type(21'd0, 0));
    expected[0] = a + b;
    expected[1] = a - b;
    expected[2] = a & b;
    expected[3] = a | b;
    expected[4] = a ^ b;
    expected[5] = auipc_pc + {{32{upper[19]}}, upper, 12'h000};
    expected[6] = '0;
    release_reset();
    wait_for_stores(7, 100);
    for (int i = 0; i < 7; i++) begin
      compare_value(mem_model.log_addr[i], DATA_BASE + 8*i, $sformatf("alu store %0d addr", i));
      compare_value(mem_model.log_data[i], expected[i], $sformatf("alu store %0d data", i));
    end
  endtask

  task automatic loads_and_stores();
    xlen_t d0;
    xlen_t d1;
    xlen_t d2;
    xlen_t d3;
    xlen_t exp_b;
    xlen_t exp_w;
    d0 = {$urandom(), $urandom()};
    d1 = {1'b1, 31'($urandom()), $urandom()}; // upper word negative
    d2 = {$urandom(), $urandom()};
    d3 = {$urandom(), $urandom()};
    start_program();
    mem_model.write_dword(DATA_BASE + 64'h40, d0);
    mem_model.write_dword(DATA_BASE + 64'h48, d1);
    mem_model.write_dword(DATA_BASE + 64'h50, d2);
    mem_model.write_dword(DATA_BASE + 64'h58, d3);
    place(u_type(20'h00001, 10, `OP_AUIPC));
    place(i_type(12'h040, 10, `F3_LD, 1, `OP_LOAD));
    place(s_type(12'd0, 1, 10, `F3_SD));
    place(i_type(12'h04c, 10, `F3_LW, 2, `OP_LOAD));
    place(s_type(12'd8, 2, 10, `F3_SD));
    place(i_type(12'h043, 10, `F3_LBU, 3, `OP_LOAD));
    place(s_type(12'd16, 3, 10, `F3_SD));
    place(s_type(12'h055, 1, 10, `F3_SB));
    place(s_type(12'h05c, 1, 10, `F3_SW));
    place(j_type(21'd0, 0));
    exp_b = d2;
    exp_b[47:40] = d0[7:0];
    exp_w = d3;
    exp_w[63:32] = d0[31:0];
    release_reset();
    wait_for_stores(5, 100);
    compare_value(mem_model.log_data[0], d0, "ld result");
    compare_value(mem_model.log_data[1], {{32{d1[63]}}, d1[63:32]}, "lw result");
    compare_value(mem_model.log_data[2], {56'h0, d0[31:24]}, "lbu result");
    compare_value(mem_model.log_mask[3], 8'h20, "sb mask");
    compare_value(mem_model.log_mask[4], 8'hf0, "sw mask");
    @(negedge clk);
    compare_value(mem_model.read_dword(DATA_BASE + 64'h50), exp_b, "memory after sb");
    compare_value(mem_model.read_dword(DATA_BASE + 64'h58), exp_w, "memory after sw");
  endtask

  task automatic branches_and_jumps();
    inst_t filler;
    filler = i_type(12'd1, 0, `F3_ADD, 3, `OP_IMM); // skipped when flow is right
    start_program();
    place(u_type(20'h00001, 10, `OP_AUIPC));          // 0x00
    place(i_type(12'd5, 0, `F3_ADD, 1, `OP_IMM));    // 0x04
    place(i_type(12'd5, 0, `F3_ADD, 2, `OP_IMM));    // 0x08
    place(b_type(13'd8, 2, 1, `F3_BEQ));             // 0x0c taken
    place(filler);                                   // 0x10
    place(b_type(13'd8, 2, 1, `F3_BNE));             // 0x14 not taken
    place(j_type(21'd12, 5));                        // 0x18
    place(filler);
    place(filler);
    place(i_type(12'd20, 5, 3'b000, 7, `OP_JALR));   // 0x24 to 0x30
    place(filler);
    place(filler);
    place(s_type(12'd0, 5, 10, `F3_SD));             // 0x30
    place(s_type(12'd8, 7, 10, `F3_SD));
    place(j_type(21'd0, 0));                         // 0x38
    expected_pcs = '{`RESET_PC, `RESET_PC + 4, `RESET_PC + 8, `RESET_PC + 12, `RESET_PC + 20,
                     `RESET_PC + 24, `RESET_PC + 36, `RESET_PC + 48, `RESET_PC + 52};
    release_reset();
    wait_for_pc(`RESET_PC + 56, 100);
    compare_trace();
    compare_value(mem_model.log_count, 2, "control flow store count");
    compare_value(mem_model.log_data[0], `RESET_PC + 28, "jal link");
    compare_value(mem_model.log_data[1], `RESET_PC + 40, "jalr link");
  endtask

  task automatic csr_and_trap();
    start_program();
    place(u_type(20'h00001, 10, `OP_AUIPC));
    place(u_type(20'h00000, 1, `OP_AUIPC));
    place(i_type(12'h03c, 1, `F3_ADD, 1, `OP_IMM));        // handler address
    place(i_type(`CSR_MTVEC, 1, `F3_CSRRW, 2, `OP_SYSTEM));
    place(s_type(12'd0, 2, 10, `F3_SD));
    place(i_type(`F12_ECALL, 0, `F3_PRIV, 0, `OP_SYSTEM)); // 0x14
    place(i_type(12'd7, 0, `F3_ADD, 9, `OP_IMM));          // return point
    place(s_type(12'd24, 9, 10, `F3_SD));
    place(j_type(21'd0, 0));
    emit_addr = `RESET_PC + 64'h40;
    place(i_type(`CSR_MEPC, 0, `F3_CSRRW, 3, `OP_SYSTEM));
    place(i_type(`CSR_MCAUSE, 0, `F3_CSRRW, 4, `OP_SYSTEM));
    place(s_type(12'd8, 3, 10, `F3_SD));
    place(s_type(12'd16, 4, 10, `F3_SD));
    place(i_type(12'd4, 3, `F3_ADD, 3, `OP_IMM));
    place(i_type(`CSR_MEPC, 3, `F3_CSRRW, 0, `OP_SYSTEM));
    place(i_type(`F12_MRET, 0, `F3_PRIV, 0, `OP_SYSTEM));  // 0x58
    for (int i = 0; i < 6; i++) begin
      expected_pcs.push_back(`RESET_PC + 4*i);
    end
    for (int i = 0; i < 7; i++) begin
      expected_pcs.push_back(`RESET_PC + 64'h40 + 4*i);
    end
    expected_pcs.push_back(`RESET_PC + 24);
    expected_pcs.push_back(`RESET_PC + 28);
    release_reset();
    wait_for_pc(`RESET_PC + 32, 100);
    compare_trace();
    compare_value(mem_model.log_count, 4, "trap store count");
    compare_value(mem_model.log_data[0], '0, "old mtvec");
    compare_value(mem_model.log_data[1], `RESET_PC + 20, "mepc");
    compare_value(mem_model.log_data[2], 64'd11, "mcause"); // ecall from machine mode
    compare_value(mem_model.log_data[3], 64'd7, "code after mret");
  endtask

  initial begin
    rst_n     = 1'b0;
    emit_addr = `RESET_PC;
    void'($urandom(32'h17c90b7c));
    reset_and_straight_line();
    alu_and_upper_imm();
    loads_and_stores();
    branches_and_jumps();
    csr_and_trap();
    $display("All checks passed");
    $finish;
  end

endmodule
